// File: rtl/ex_isa_pkg.sv
package ex_isa_pkg;

    // ********************
    // Major opcodes
    // ********************
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Arithmetic funct3 shared by OP and OP-IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    // ********************
    // Field positions
    // ********************
    localparam int OPCODE_MSB     = 6;
    localparam int OPCODE_LSB     = 0;
    localparam int FUNCT3_MSB     = 14;
    localparam int FUNCT3_LSB     = 12;
    localparam int FUNCT7_ALT_BIT = 30;  // Selects sub and sra.
    localparam int IMM_I_MSB      = 31;
    localparam int IMM_I_LSB      = 20;
    localparam int IMM_B_SIGN     = 31;  // imm[12].
    localparam int IMM_B_B11      = 7;   // imm[11].
    localparam int IMM_B_HI_MSB   = 30;  // imm[10:5].
    localparam int IMM_B_HI_LSB   = 25;
    localparam int IMM_B_LO_MSB   = 11;  // imm[4:1].
    localparam int IMM_B_LO_LSB   = 8;

endpackage

// File: rtl/ex_uop_pkg.sv
package ex_uop_pkg;

    // ********************
    // ALU micro-ops
    // ********************
    typedef enum logic [2:0] {
        ALU_ADD = 3'b011,
        ALU_SUB = 3'b100,  // Also used for slt and sltu.
        ALU_XOR = 3'b101,
        ALU_OR  = 3'b110,
        ALU_AND = 3'b111
    } alu_op_e;

    // ********************
    // Shift micro-ops
    // ********************
    typedef enum logic [1:0] {
        SHIFT_SLL = 2'b00,
        SHIFT_SRL = 2'b01,
        SHIFT_SRA = 2'b10
    } shift_op_e;

    // ********************
    // Result source
    // ********************
    typedef enum logic [1:0] {
        RES_ALU   = 2'b00,
        RES_SHIFT = 2'b01,
        RES_ZERO  = 2'b10  // Branches and illegal.
    } res_sel_e;

endpackage

// File: rtl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu #(
    parameter int XLEN = 64
) (
    input  ex_uop_pkg::alu_op_e alu_op_i,
    input  logic                slt_signed_i,
    input  logic                slt_unsigned_i,
    input  logic [XLEN-1:0]     op1_i,
    input  logic [XLEN-1:0]     op2_i,
    output logic [XLEN-1:0]     res_o
);

    logic            alu_add;
    logic            alu_sub;
    logic            alu_xor;
    logic            alu_or;
    logic            alu_and;
    logic            is_slt;
    logic            op_signed;
    logic            arith_en;
    logic [XLEN:0]   ext_op1;
    logic [XLEN:0]   ext_op2;
    logic [XLEN:0]   arith_res;
    logic [XLEN-1:0] slt_res;

    // ********************
    // Op decode
    // ********************
    assign alu_add   = (alu_op_i == ex_uop_pkg::ALU_ADD);
    assign alu_sub   = (alu_op_i == ex_uop_pkg::ALU_SUB);
    assign alu_xor   = (alu_op_i == ex_uop_pkg::ALU_XOR);
    assign alu_or    = (alu_op_i == ex_uop_pkg::ALU_OR);
    assign alu_and   = (alu_op_i == ex_uop_pkg::ALU_AND);
    assign is_slt    = slt_signed_i | slt_unsigned_i;
    assign op_signed = ~slt_unsigned_i;
    assign arith_en  = alu_add | (alu_sub & ~is_slt);

    // One extra bit so the borrow carries the compare.
    assign ext_op1 = {op_signed & op1_i[XLEN-1], op1_i};
    assign ext_op2 = {op_signed & op2_i[XLEN-1], op2_i};

    assign arith_res = ext_op1 + (alu_sub ? (~ext_op2 + 1'b1) : ext_op2);
    assign slt_res   = {{(XLEN-1){1'b0}}, arith_res[XLEN]};  // Sign of difference.

    // ********************
    // Result mux
    // ********************
    assign res_o = ({XLEN{arith_en}} & arith_res[XLEN-1:0])
                 | ({XLEN{alu_xor}}  & (op1_i ^ op2_i))
                 | ({XLEN{alu_or}}   & (op1_i | op2_i))
                 | ({XLEN{alu_and}}  & (op1_i & op2_i))
                 | ({XLEN{is_slt}}   & slt_res);

endmodule

// File: rtl/ex_shifter.sv
`timescale 1ns/1ps

module ex_shifter #(
    parameter int XLEN = 64
) (
    input  ex_uop_pkg::shift_op_e shift_op_i,
    input  logic [XLEN-1:0]       op1_i,
    input  logic [XLEN-1:0]       op2_i,
    output logic [XLEN-1:0]       res_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = op2_i[SHAMT_W-1:0];  // Upper bits ignored.

    always_comb begin
        case (shift_op_i)
            ex_uop_pkg::SHIFT_SLL: begin
                res_o = op1_i << shamt;
            end
            ex_uop_pkg::SHIFT_SRL: begin
                res_o = op1_i >> shamt;
            end
            ex_uop_pkg::SHIFT_SRA: begin
                res_o = $signed(op1_i) >>> shamt;  // Sign fill.
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

// File: rtl/ex_branch.sv
`timescale 1ns/1ps

module ex_branch #(
    parameter int XLEN = 64
) (
    input  logic [2:0]      funct3_i,
    input  logic [31:0]     inst_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o
);

    logic        eq;
    logic        lt;
    logic        ltu;
    logic [12:0] imm_b;

    assign eq  = (rs1_i == rs2_i);
    assign lt  = ($signed(rs1_i) < $signed(rs2_i));
    assign ltu = (rs1_i < rs2_i);

    always_comb begin
        case (funct3_i)
            ex_isa_pkg::F3_BEQ:  taken_o = eq;
            ex_isa_pkg::F3_BNE:  taken_o = ~eq;
            ex_isa_pkg::F3_BLT:  taken_o = lt;
            ex_isa_pkg::F3_BGE:  taken_o = ~lt;
            ex_isa_pkg::F3_BLTU: taken_o = ltu;
            ex_isa_pkg::F3_BGEU: taken_o = ~ltu;
            default:             taken_o = 1'b0;  // 010 and 011.
        endcase
    end

    // ********************
    // Target
    // ********************
    assign imm_b = {inst_i[ex_isa_pkg::IMM_B_SIGN],
                    inst_i[ex_isa_pkg::IMM_B_B11],
                    inst_i[ex_isa_pkg::IMM_B_HI_MSB:ex_isa_pkg::IMM_B_HI_LSB],
                    inst_i[ex_isa_pkg::IMM_B_LO_MSB:ex_isa_pkg::IMM_B_LO_LSB],
                    1'b0};

    assign target_o = pc_i + {{(XLEN-13){imm_b[12]}}, imm_b};

endmodule

// File: rtl/ex_ctrl.sv
`timescale 1ns/1ps

module ex_ctrl #(
    parameter int XLEN = 64
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  logic [31:0]           inst_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output logic [XLEN-1:0]       result_o,
    output logic                  br_taken_o,
    output logic [XLEN-1:0]       br_target_o,
    output logic                  illegal_o,
    output ex_uop_pkg::alu_op_e   alu_op_o,
    output logic                  slt_signed_o,
    output logic                  slt_unsigned_o,
    output ex_uop_pkg::shift_op_e shift_op_o,
    output logic [XLEN-1:0]       op2_o,
    output logic [2:0]            funct3_o,
    input  logic [XLEN-1:0]       alu_res_i,
    input  logic [XLEN-1:0]       shift_res_i,
    input  logic                  br_cond_i,
    input  logic [XLEN-1:0]       br_target_i
);

    localparam int IMM_I_W = ex_isa_pkg::IMM_I_MSB - ex_isa_pkg::IMM_I_LSB + 1;

    logic [6:0]           opcode;
    logic                 alt;
    logic                 is_op;
    logic [IMM_I_W-1:0]   imm_i;
    ex_uop_pkg::res_sel_e res_sel;
    logic                 is_branch;
    logic                 illegal;
    logic                 accept;
    logic [XLEN-1:0]      result_d;

    assign opcode   = inst_i[ex_isa_pkg::OPCODE_MSB:ex_isa_pkg::OPCODE_LSB];
    assign funct3_o = inst_i[ex_isa_pkg::FUNCT3_MSB:ex_isa_pkg::FUNCT3_LSB];
    assign alt      = inst_i[ex_isa_pkg::FUNCT7_ALT_BIT];
    assign is_op    = (opcode == ex_isa_pkg::OPC_OP);
    assign imm_i    = inst_i[ex_isa_pkg::IMM_I_MSB:ex_isa_pkg::IMM_I_LSB];
    assign op2_o    = is_op ? rs2_data_i : {{(XLEN-IMM_I_W){imm_i[IMM_I_W-1]}}, imm_i};

    // ********************
    // Decode
    // ********************
    always_comb begin
        alu_op_o       = ex_uop_pkg::ALU_ADD;
        slt_signed_o   = 1'b0;
        slt_unsigned_o = 1'b0;
        shift_op_o     = ex_uop_pkg::SHIFT_SLL;
        res_sel        = ex_uop_pkg::RES_ZERO;
        is_branch      = 1'b0;
        illegal        = 1'b0;
        case (opcode)
            ex_isa_pkg::OPC_OP, ex_isa_pkg::OPC_OP_IMM: begin
                res_sel = ex_uop_pkg::RES_ALU;
                case (funct3_o)
                    ex_isa_pkg::F3_ADD_SUB: begin
                        alu_op_o = (is_op && alt) ? ex_uop_pkg::ALU_SUB : ex_uop_pkg::ALU_ADD;
                    end
                    ex_isa_pkg::F3_SLL: begin
                        res_sel = ex_uop_pkg::RES_SHIFT;
                    end
                    ex_isa_pkg::F3_SLT: begin
                        alu_op_o     = ex_uop_pkg::ALU_SUB;
                        slt_signed_o = 1'b1;
                    end
                    ex_isa_pkg::F3_SLTU: begin
                        alu_op_o       = ex_uop_pkg::ALU_SUB;
                        slt_unsigned_o = 1'b1;
                    end
                    ex_isa_pkg::F3_XOR: alu_op_o = ex_uop_pkg::ALU_XOR;
                    ex_isa_pkg::F3_SRL_SRA: begin
                        res_sel    = ex_uop_pkg::RES_SHIFT;
                        shift_op_o = alt ? ex_uop_pkg::SHIFT_SRA : ex_uop_pkg::SHIFT_SRL;
                    end
                    ex_isa_pkg::F3_OR: alu_op_o = ex_uop_pkg::ALU_OR;
                    default: alu_op_o = ex_uop_pkg::ALU_AND;
                endcase
            end
            ex_isa_pkg::OPC_BRANCH: begin
                case (funct3_o)
                    ex_isa_pkg::F3_BEQ, ex_isa_pkg::F3_BNE,
                    ex_isa_pkg::F3_BLT, ex_isa_pkg::F3_BGE,
                    ex_isa_pkg::F3_BLTU, ex_isa_pkg::F3_BGEU: is_branch = 1'b1;
                    default: illegal = 1'b1;  // Undefined funct3.
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (res_sel)
            ex_uop_pkg::RES_ALU:   result_d = alu_res_i;
            ex_uop_pkg::RES_SHIFT: result_d = shift_res_i;
            default:               result_d = '0;
        endcase
    end

    // ********************
    // Output register
    // ********************
    assign in_ready_o = ~out_valid_o | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;  // Drained.
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            result_o    <= result_d;
            br_taken_o  <= is_branch & br_cond_i;
            br_target_o <= is_branch ? br_target_i : '0;
            illegal_o   <= illegal;
        end
    end

endmodule

// File: rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
    parameter int XLEN = 64
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  logic [31:0]     inst_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output logic [XLEN-1:0] result_o,
    output logic            br_taken_o,
    output logic [XLEN-1:0] br_target_o,
    output logic            illegal_o
);

    ex_uop_pkg::alu_op_e   alu_op;
    ex_uop_pkg::shift_op_e shift_op;
    logic                  slt_signed;
    logic                  slt_unsigned;
    logic [XLEN-1:0]       op2;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       shift_res;
    logic                  br_cond;
    logic [XLEN-1:0]       br_target;

    ex_ctrl #(
        .XLEN (XLEN)
    ) u_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .inst_i         (inst_i),
        .rs2_data_i     (rs2_data_i),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .result_o       (result_o),
        .br_taken_o     (br_taken_o),
        .br_target_o    (br_target_o),
        .illegal_o      (illegal_o),
        .alu_op_o       (alu_op),
        .slt_signed_o   (slt_signed),
        .slt_unsigned_o (slt_unsigned),
        .shift_op_o     (shift_op),
        .op2_o          (op2),
        .funct3_o       (funct3),
        .alu_res_i      (alu_res),
        .shift_res_i    (shift_res),
        .br_cond_i      (br_cond),
        .br_target_i    (br_target)
    );

    ex_alu #(
        .XLEN (XLEN)
    ) u_alu (
        .alu_op_i       (alu_op),
        .slt_signed_i   (slt_signed),
        .slt_unsigned_i (slt_unsigned),
        .op1_i          (rs1_data_i),
        .op2_i          (op2),
        .res_o          (alu_res)
    );

    ex_shifter #(
        .XLEN (XLEN)
    ) u_shifter (
        .shift_op_i (shift_op),
        .op1_i      (rs1_data_i),
        .op2_i      (op2),
        .res_o      (shift_res)
    );

    // Branch unit reads the raw register operands.
    ex_branch #(
        .XLEN (XLEN)
    ) u_branch (
        .funct3_i (funct3),
        .inst_i   (inst_i),
        .pc_i     (pc_i),
        .rs1_i    (rs1_data_i),
        .rs2_i    (rs2_data_i),
        .taken_o  (br_cond),
        .target_o (br_target)
    );

endmodule

// File: dv/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int XLEN    = 64;
    localparam int TIMEOUT = 100;

    localparam logic [6:0]  OPC_R    = 7'b0110011;
    localparam logic [6:0]  OPC_I    = 7'b0010011;
    localparam logic [6:0]  OPC_B    = 7'b1100011;
    localparam logic [63:0] ALL_ONES = 64'hffff_ffff_ffff_ffff;
    localparam logic [63:0] MSB_ONLY = 64'h8000_0000_0000_0000;
    localparam logic [63:0] BR_PC    = 64'h0000_0000_8000_1000;

    logic            clk_i;
    logic            rst_n_i;
    logic            in_valid_i;
    logic            in_ready_o;
    logic [31:0]     inst_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] rs1_data_i;
    logic [XLEN-1:0] rs2_data_i;
    logic            out_valid_o;
    logic            out_ready_i;
    logic [XLEN-1:0] result_o;
    logic            br_taken_o;
    logic [XLEN-1:0] br_target_o;
    logic            illegal_o;

    // One index per test in each queue.
    string       t_name[$];
    logic [31:0] t_inst[$];
    logic [63:0] t_pc[$];
    logic [63:0] t_rs1[$];
    logic [63:0] t_rs2[$];
    logic [63:0] t_res[$];
    logic        t_taken[$];
    logic [63:0] t_target[$];
    logic        t_ill[$];

    integer      seed = 32'h20fa_145c;
    integer      rnd;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          other_err = 0;
    int          extra;
    bit          timed_out = 1'b0;
    bit          held = 1'b0;
    bit          accept_seen = 1'b0;
    logic [63:0] held_res;
    logic        held_taken;
    logic [63:0] held_target;
    logic        held_ill;

    ex_stage #(
        .XLEN (XLEN)
    ) UUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o),
        .br_taken_o  (br_taken_o),
        .br_target_o (br_target_o),
        .illegal_o   (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        rnd = $random(seed);
        out_ready_i <= rnd[0];  // Random back-pressure.
    end

    // ********************
    // Instruction encoding
    // ********************
    function automatic logic [31:0] r_inst(input logic alt, input logic [2:0] f3);
        r_inst = {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, 5'd3, OPC_R};
    endfunction

    function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [2:0] f3);
        i_inst = {imm, 5'd1, f3, 5'd3, OPC_I};
    endfunction

    function automatic logic [31:0] b_inst(input logic [12:0] imm, input logic [2:0] f3);
        b_inst = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_B};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] inst,
                             input logic [63:0] pc, input logic [63:0] rs1,
                             input logic [63:0] rs2, input logic [63:0] res,
                             input logic taken, input logic [63:0] target, input logic ill);
        t_name.push_back(name);
        t_inst.push_back(inst);
        t_pc.push_back(pc);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_res.push_back(res);
        t_taken.push_back(taken);
        t_target.push_back(target);
        t_ill.push_back(ill);
    endtask

    task automatic add_alu(input string name, input logic [31:0] inst,
                           input logic [63:0] rs1, input logic [63:0] rs2,
                           input logic [63:0] res);
        add_entry(name, inst, 64'd0, rs1, rs2, res, 1'b0, 64'd0, 1'b0);
    endtask

    task automatic add_br(input string name, input logic [2:0] f3, input logic [12:0] imm,
                          input logic [63:0] rs1, input logic [63:0] rs2,
                          input logic taken, input logic [63:0] target);
        add_entry(name, b_inst(imm, f3), BR_PC, rs1, rs2, 64'd0, taken, target, 1'b0);
    endtask

    task automatic build_table();
        add_alu("add", r_inst(1'b0, 3'b000), 64'h7fff_ffff_ffff_ffff, 64'd1, MSB_ONLY);
        add_alu("add_wrap", r_inst(1'b0, 3'b000), ALL_ONES, 64'd2, 64'd1);
        add_alu("sub", r_inst(1'b1, 3'b000), 64'd5, 64'd7, 64'hffff_ffff_ffff_fffe);
        add_alu("xor", r_inst(1'b0, 3'b100), 64'hf0f0_f0f0_0000_ffff,
                64'hff00_ff00_ffff_0000, 64'h0ff0_0ff0_ffff_ffff);
        add_alu("or", r_inst(1'b0, 3'b110), 64'hf0f0_f0f0_0000_ffff,
                64'hff00_ff00_ffff_0000, 64'hfff0_fff0_ffff_ffff);
        add_alu("and", r_inst(1'b0, 3'b111), 64'hf0f0_f0f0_0000_ffff,
                64'hff00_ff00_ffff_0000, 64'hf000_f000_0000_0000);
        add_alu("slt_mixed", r_inst(1'b0, 3'b010), ALL_ONES, 64'd1, 64'd1);
        add_alu("sltu_mixed", r_inst(1'b0, 3'b011), ALL_ONES, 64'd1, 64'd0);
        add_alu("slt_equal", r_inst(1'b0, 3'b010), MSB_ONLY, MSB_ONLY, 64'd0);
        add_alu("sltu_equal", r_inst(1'b0, 3'b011), ALL_ONES, ALL_ONES, 64'd0);
        add_alu("sll", r_inst(1'b0, 3'b001), 64'd1, 64'h44, 64'h10);  // Bit 6 ignored.
        add_alu("srl", r_inst(1'b0, 3'b101), MSB_ONLY, 64'h7f, 64'd1);
        add_alu("sra", r_inst(1'b1, 3'b101), MSB_ONLY, 64'h3c, 64'hffff_ffff_ffff_fff8);
        add_alu("slli", i_inst(12'h021, 3'b001), 64'd3, ALL_ONES, 64'h0000_0006_0000_0000);
        add_alu("srli", i_inst(12'h03c, 3'b101), ALL_ONES, ALL_ONES, 64'hf);
        add_alu("srai", i_inst(12'h404, 3'b101), 64'hf000_0000_0000_0000, ALL_ONES,
                64'hff00_0000_0000_0000);
        add_alu("addi", i_inst(12'hffd, 3'b000), 64'd10, ALL_ONES, 64'd7);
        add_alu("addi_b30", i_inst(12'h400, 3'b000), 64'd1, ALL_ONES, 64'h401);  // No sub.
        add_alu("xori", i_inst(12'hfff, 3'b100), 64'h0f0f, ALL_ONES, 64'hffff_ffff_ffff_f0f0);
        add_alu("ori", i_inst(12'h800, 3'b110), 64'd0, ALL_ONES, 64'hffff_ffff_ffff_f800);
        add_alu("andi", i_inst(12'hf00, 3'b111), 64'hffff_ffff_1234_5678, ALL_ONES,
                64'hffff_ffff_1234_5600);
        add_alu("slti", i_inst(12'hffc, 3'b010), 64'hffff_ffff_ffff_fffb, ALL_ONES, 64'd1);

        add_br("beq_t", 3'b000, 13'h0010, 64'd5, 64'd5, 1'b1, 64'h8000_1010);
        add_br("beq_n", 3'b000, 13'h1ff0, 64'd5, 64'd6, 1'b0, 64'h8000_0ff0);
        add_br("bne_t", 3'b001, 13'h0800, 64'd5, 64'd6, 1'b1, 64'h8000_1800);
        add_br("bne_n", 3'b001, 13'h1000, 64'd7, 64'd7, 1'b0, 64'h8000_0000);
        add_br("blt_t", 3'b100, 13'h0008, ALL_ONES, 64'd1, 1'b1, 64'h8000_1008);
        add_br("blt_n", 3'b100, 13'h0008, 64'd1, ALL_ONES, 1'b0, 64'h8000_1008);
        add_br("bge_t", 3'b101, 13'h1ff8, 64'd1, ALL_ONES, 1'b1, 64'h8000_0ff8);
        add_br("bge_n", 3'b101, 13'h1ff8, ALL_ONES, 64'd1, 1'b0, 64'h8000_0ff8);
        add_br("bltu_t", 3'b110, 13'h0004, 64'd1, ALL_ONES, 1'b1, 64'h8000_1004);
        add_br("bltu_n", 3'b110, 13'h0004, ALL_ONES, 64'd1, 1'b0, 64'h8000_1004);
        add_br("bgeu_t", 3'b111, 13'h0ffe, ALL_ONES, 64'd1, 1'b1, 64'h8000_1ffe);
        add_br("bgeu_n", 3'b111, 13'h0ffe, 64'd1, ALL_ONES, 1'b0, 64'h8000_1ffe);

        add_entry("lui_illegal", 32'h1234_50b7, 64'd0, 64'd3, 64'd4,
                  64'd0, 1'b0, 64'd0, 1'b1);
        add_entry("br_f3_010", b_inst(13'h0010, 3'b010), BR_PC, 64'd5, 64'd5,
                  64'd0, 1'b0, 64'd0, 1'b1);
        add_entry("br_f3_011", b_inst(13'h0010, 3'b011), BR_PC, 64'd5, 64'd5,
                  64'd0, 1'b0, 64'd0, 1'b1);
    endtask

    // ********************
    // Driver and checker
    // ********************
    task automatic drive_items();
        int i;
        int cycles;
        bit accepted;
        i = 0;
        while (i < t_name.size() && !timed_out) begin
            in_valid_i <= 1'b1;
            inst_i     <= t_inst[i];
            pc_i       <= t_pc[i];
            rs1_data_i <= t_rs1[i];
            rs2_data_i <= t_rs2[i];
            accepted = 1'b0;
            cycles   = 0;
            while (!accepted && cycles < TIMEOUT) begin
                @(posedge clk_i);
                cycles++;
                accepted = (in_ready_o === 1'b1);
            end
            if (!accepted) begin
                $display("Timeout: the DUT never accepted item %s", t_name[i]);
                timed_out = 1'b1;
            end
            i++;
        end
        in_valid_i <= 1'b0;
    endtask

    task automatic check_items();
        int k;
        int cycles;
        bit got;
        bit ok;
        k = 0;
        while (k < t_name.size() && !timed_out) begin
            got    = 1'b0;
            cycles = 0;
            while (!got && cycles < TIMEOUT) begin
                @(posedge clk_i);
                cycles++;
                got = (out_valid_o === 1'b1) && (out_ready_i === 1'b1);
            end
            if (!got) begin
                $display("Timeout: no output arrived for item %s", t_name[k]);
                timed_out = 1'b1;
            end else begin
                ok = 1'b1;
                if (result_o !== t_res[k]) begin
                    $display("** Error %s: result expected %h, actual %h",
                             t_name[k], t_res[k], result_o);
                    ok = 1'b0;
                end
                if (br_taken_o !== t_taken[k]) begin
                    $display("** Error %s: taken expected %b, actual %b",
                             t_name[k], t_taken[k], br_taken_o);
                    ok = 1'b0;
                end
                if (br_target_o !== t_target[k]) begin
                    $display("** Error %s: target expected %h, actual %h",
                             t_name[k], t_target[k], br_target_o);
                    ok = 1'b0;
                end
                if (illegal_o !== t_ill[k]) begin
                    $display("** Error %s: illegal expected %b, actual %b",
                             t_name[k], t_ill[k], illegal_o);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_cnt++;
                    $display("test %s: passed", t_name[k]);
                end else begin
                    fail_cnt++;
                    $display("test %s: failed", t_name[k]);
                end
            end
            k++;
        end
    endtask

    // Held outputs must not move and in_ready_o must follow the register state.
    always @(posedge clk_i) begin
        if (held && (out_valid_o !== 1'b1 || result_o !== held_res
                || br_taken_o !== held_taken || br_target_o !== held_target
                || illegal_o !== held_ill)) begin
            $display("Outputs changed while held by back-pressure at %0t", $time);
            other_err++;
        end
        if (accept_seen && out_valid_o !== 1'b1) begin
            $display("out_valid_o was not high one cycle after an accept at %0t", $time);
            other_err++;
        end
        if (out_valid_o === 1'b1 && out_ready_i === 1'b0 && in_ready_o !== 1'b0) begin
            $display("in_ready_o was not low under back-pressure at %0t", $time);
            other_err++;
        end
        if (rst_n_i === 1'b1 && (out_valid_o === 1'b0 || out_ready_i === 1'b1)
                && in_ready_o !== 1'b1) begin
            $display("in_ready_o was low while the register could take an item at %0t",
                     $time);
            other_err++;
        end
        held        = (rst_n_i === 1'b1) && (out_valid_o === 1'b1) && (out_ready_i === 1'b0);
        accept_seen = (rst_n_i === 1'b1) && (in_valid_i === 1'b1) && (in_ready_o === 1'b1);
        held_res    = result_o;
        held_taken  = br_taken_o;
        held_target = br_target_o;
        held_ill    = illegal_o;
    end

    initial begin
        rst_n_i     <= 1'b0;
        in_valid_i  <= 1'b0;
        inst_i      <= '0;
        pc_i        <= '0;
        rs1_data_i  <= '0;
        rs2_data_i  <= '0;
        out_ready_i <= 1'b0;
        extra       = 0;
        build_table();

        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
            $display("** Error reset: valid/ready expected 0/1, actual %b/%b",
                     out_valid_o, in_ready_o);
            fail_cnt++;
            $display("test reset: failed");
        end else begin
            pass_cnt++;
            $display("test reset: passed");
        end

        fork
            drive_items();
            check_items();
        join

        repeat (10) begin
            @(posedge clk_i);
            if (out_valid_o === 1'b1 && out_ready_i === 1'b1) begin
                extra++;
            end
        end
        if (extra != 0) begin
            $display("The DUT delivered %0d more items than were sent", extra);
            other_err++;
        end

        $display("Summary: %0d passed, %0d failed, %0d other errors",
                 pass_cnt, fail_cnt, other_err);
        if (!timed_out && fail_cnt == 0 && other_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/ex_isa_pkg.sv
rtl/ex_uop_pkg.sv
rtl/ex_alu.sv
rtl/ex_shifter.sv
rtl/ex_branch.sv
rtl/ex_ctrl.sv
rtl/ex_stage.sv
dv/ex_stage_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f compile.f --top-module ex_stage_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vex_stage_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
